//--- flist.f
spif_io_pkg.sv
spif_boot_pkg.sv
uart_tx_escape.sv
uart_rx_unescape.sv
flash_boot.sv
cpu_io_regs.sv
spif_top.sv
tb_flash_model.sv
tb_spif.sv

//--- tb_spif.sv
`timescale 1ns/10ps
//==============================
// flash boot controller testbench
//==============================
module tb_spif;

  localparam int WIDTH     = 18;
  localparam int CODE_SIZE = 10;
  localparam int DATA_SIZE = 10;
  localparam int BASEBLOCK = 2;                          // visible sector byte
  localparam logic [15:0] CODE_MASK = (1 << CODE_SIZE) - 1;
  localparam logic [15:0] DATA_MASK = (1 << DATA_SIZE) - 1;

  //==============================
  // stimulus data
  //==============================
  localparam int IMG_LEN = 29;
  localparam logic [8*IMG_LEN-1:0] IMAGE = {
    8'hC0, 8'h00, 8'h10,                                 // dest 0010h
    8'hC1, 8'h00, 8'h01,                                 // two words
    8'h01, 8'hAB, 8'hCD, 8'h12, 8'h34,                   // code sink with 2 byte words
    8'h80,                                               // rate byte
    8'hC0, 8'h00, 8'h20,                                 // dest 0020h
    8'hC1, 8'h00, 8'h02,                                 // three words
    8'h06, 8'h01, 8'h23, 8'h45, 8'h3F, 8'hFF, 8'hFF,     // data sink with 3 byte words
    8'hA5, 8'h5A, 8'hC3,
    8'hE0                                                // end with reset low
  };
  localparam logic [47:0] RX_RAW = 48'h41_10_02_10_07_55; // raw UART input
  localparam logic [23:0] RX_EXP = 24'h41_12_55;          // after unescape
  localparam logic [23:0] TX_IN  = 24'h20_11_13;          // processor writes
  localparam logic [39:0] TX_EXP = 40'h20_10_01_10_03;    // on the wire
  localparam logic [47:0] CODE_W = 48'h1F2E_BEEF_0007;    // processor code words
  localparam int LIMIT = 40 * IMG_LEN + 40 * (6 + 5) + 500;

  logic                 clk;
  logic                 arstn;
  logic                 io_rd;
  logic                 io_wr;
  logic                 mem_rd;
  logic                 mem_wr;
  logic [14:0]          mem_addr;
  logic [WIDTH-1:0]     din;
  logic [14:0]          code_addr;
  logic [WIDTH-1:0]     io_dout;
  logic                 p_hold;
  logic                 p_reset;
  logic [DATA_SIZE-1:0] data_a;
  logic [WIDTH-1:0]     data_din;
  logic                 data_wr;
  logic                 data_rd;
  logic [CODE_SIZE-1:0] code_a;
  logic [15:0]          code_din;
  logic                 code_wr;
  logic                 code_rd;
  logic                 u_ready;
  logic                 u_wr;
  logic [7:0]           u_dout;
  logic                 u_full;
  logic                 u_rd;
  logic [7:0]           u_din;
  logic                 f_ready;
  logic                 f_wr;
  logic [7:0]           f_dout;
  logic [2:0]           f_format;
  logic [7:0]           f_din;

  logic [15:0] code_a16;
  logic [15:0] data_a16;
  logic [34:0] exp_wr[$];      // {sink, addr, word}
  logic [7:0]  flash_seen[$];
  logic [7:0]  tx_seen[$];
  logic [7:0]  rx_feed[$];
  logic        u_ready_d;      // previous cycle for protocol checks
  logic        u_wr_d;
  int          u_gap;
  int          errors;
  int          checks;
  int          cycles;
  int          seed;
  int unsigned rnd;
  int          i;
  logic [WIDTH-1:0] val;
  logic [15:0] a16;
  logic [7:0]  exp_b;
  logic        final_rst;

  assign code_a16 = code_a;    // zero extend
  assign data_a16 = data_a;

  spif_top #(
    .CODE_SIZE(CODE_SIZE), .WIDTH(WIDTH), .DATA_SIZE(DATA_SIZE), .BASEBLOCK(BASEBLOCK)
  ) dut0 (
    .clk(clk), .arstn(arstn),
    .i_io_rd(io_rd), .i_io_wr(io_wr), .i_mem_rd(mem_rd), .i_mem_wr(mem_wr),
    .i_mem_addr(mem_addr), .i_din(din), .i_code_addr(code_addr),
    .o_io_dout(io_dout), .o_p_hold(p_hold), .o_p_reset(p_reset),
    .o_data_a(data_a), .o_data_din(data_din), .o_data_wr(data_wr), .o_data_rd(data_rd),
    .o_code_a(code_a), .o_code_din(code_din), .o_code_wr(code_wr), .o_code_rd(code_rd),
    .i_u_ready(u_ready), .o_u_wr(u_wr), .o_u_dout(u_dout),
    .i_u_full(u_full), .o_u_rd(u_rd), .i_u_din(u_din),
    .i_f_ready(f_ready), .o_f_wr(f_wr), .o_f_dout(f_dout), .o_f_format(f_format),
    .i_f_din(f_din)
  );

  tb_flash_model #(.IMG_LEN(IMG_LEN), .IMAGE(IMAGE)) flash0 (
    .clk(clk), .arstn(arstn), .i_f_wr(f_wr), .o_f_ready(f_ready), .o_f_din(f_din)
  );

  always #5 clk = ~clk;

  task automatic check(input logic [35:0] got, input logic [35:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [7:0] img_byte(input int k);
    return IMAGE[8*(IMG_LEN-1-k) +: 8];
  endfunction

  // expected RAM writes from the image format and the final cpu reset level
  function automatic logic decode_image();
    int          k;
    int          w;
    int          b;
    logic [7:0]  c;
    logic [15:0] dest;
    logic [15:0] cnt;
    logic [23:0] acc;
    k    = 0;
    dest = '0;
    cnt  = '0;
    while (k < IMG_LEN) begin
      c = img_byte(k);
      k++;
      if (c[7:6] == 2'b11 && c[5]) begin
        return c[4];                                     // end command
      end else if (c[7:6] == 2'b11) begin
        if (c[0])
          cnt = {img_byte(k), img_byte(k + 1)};          // count msb first
        else
          dest = {img_byte(k), img_byte(k + 1)};
        k += 2;
      end else if (c[7:6] != 2'b10) begin                // rate bytes skipped
        for (w = 0; w <= cnt; w++) begin
          acc = '0;
          for (b = 0; b <= c[1:0]; b++) begin
            acc = {acc[15:0], img_byte(k)};
            k++;
          end
          if (c[4:2] == 3'd0)
            exp_wr.push_back({1'b0, dest & CODE_MASK, 2'b00, acc[15:0]});
          else if (c[4:2] == 3'd1)
            exp_wr.push_back({1'b1, dest & DATA_MASK, acc[WIDTH-1:0]});
          dest++;                                        // other sinks just advance
        end
        cnt = '0;
      end
    end
    return 1'b1;
  endfunction

  task automatic match_ram_write(input logic [34:0] got);
    if (exp_wr.size() == 0) begin
      errors++;
      $display("unexpected RAM write %0h at %0t", got, $time);
    end else begin
      check(got, exp_wr.pop_front(), "RAM write {sink,addr,word}");
    end
  endtask

  //==============================
  // processor bus
  //==============================
  task automatic read_reg(input logic [3:0] sel, output logic [WIDTH-1:0] rd_val);
    @(negedge clk);
    mem_addr = {11'd0, sel};
    io_rd    = 1'b1;
    @(posedge clk);
    while (p_hold)                     // strobe counts once hold is low
      @(posedge clk);
    rd_val = io_dout;
    @(negedge clk);
    io_rd = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] sel, input logic [WIDTH-1:0] wr_val);
    @(negedge clk);
    mem_addr = {11'd0, sel};
    din      = wr_val;
    io_wr    = 1'b1;
    @(posedge clk);
    while (p_hold)
      @(posedge clk);
    @(negedge clk);
    io_wr = 1'b0;
  endtask

  //==============================
  // UART models
  //==============================
  always @(negedge clk or negedge arstn) begin
    if (!arstn) begin
      u_ready <= 1'b1;
      u_gap   <= 0;
    end else if (u_wr) begin
      u_ready <= 1'b0;                 // byte in flight
      u_gap   <= $urandom % 4;
    end else if (!u_ready) begin
      if (u_gap == 0)
        u_ready <= 1'b1;
      else
        u_gap <= u_gap - 1;
    end
  end

  always @(negedge clk or negedge arstn) begin
    if (!arstn) begin
      u_full <= 1'b0;
      u_din  <= 8'h00;
    end else if (u_rd || !u_full) begin
      if (rx_feed.size() > 0) begin    // next raw byte
        u_full <= 1'b1;
        u_din  <= rx_feed.pop_front();
      end else begin
        u_full <= 1'b0;
      end
    end
  end

  // compare process and output logging
  always @(posedge clk) begin
    if (arstn) begin
      if (code_wr)
        match_ram_write({1'b0, code_a16, 2'b00, code_din});
      if (data_wr)
        match_ram_write({1'b1, data_a16, data_din});
      if ((code_wr || data_wr) && f_format == spif_boot_pkg::FMT_SINGLE) begin
        check(p_hold, 1'b1, "hold during boot write");
        check(code_rd, 1'b0, "fetch during boot write");
      end
      if (f_wr) begin
        flash_seen.push_back(f_dout);
        check(f_format, spif_boot_pkg::FMT_SINGLE, "flash format in transfer");
      end
      if (u_wr) begin
        tx_seen.push_back(u_dout);
        check(u_ready_d, 1'b1, "uart ready before write");
        check(u_wr_d, 1'b0, "uart write gap");
      end
    end
    u_ready_d <= u_ready;
    u_wr_d    <= u_wr;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", LIMIT);
      $display("checks %0d, errors %0d", checks, errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    seed = 91;
    rnd  = $urandom(seed);
    clk       = 1'b0;
    arstn     = 1'b1;
    io_rd     = 1'b0;
    io_wr     = 1'b0;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    mem_addr  = '0;
    din       = '0;
    code_addr = '0;
    final_rst = decode_image();
    for (i = 0; i < 6; i++)
      rx_feed.push_back(RX_RAW[8*(5-i) +: 8]);
    #1 arstn = 1'b0;                   // clean edge for the models
    repeat (3) @(posedge clk);
    @(negedge clk);
    arstn = 1'b1;
    check(p_reset, 1'b1, "cpu reset after reset");
    check(f_format, spif_boot_pkg::FMT_OFF, "flash format after reset");

    // boot runs from the first transfer until CS# goes high again
    wait (f_format == spif_boot_pkg::FMT_SINGLE);
    wait (f_format == spif_boot_pkg::FMT_OFF);
    @(negedge clk);
    check(p_reset, final_rst, "cpu reset level after boot");
    check(flash_seen.size(), 5 + IMG_LEN, "flash transfer count");
    for (i = 0; i < flash_seen.size(); i++) begin
      if (i == 0)
        exp_b = 8'h0B;                 // fast read
      else if (i == 1)
        exp_b = BASEBLOCK;
      else
        exp_b = 8'h00;
      check(flash_seen[i], exp_b, $sformatf("flash byte %0d", i));
    end
    check(exp_wr.size(), 0, "boot writes left over");
    read_reg(spif_io_pkg::IO_BOOTING, val);
    check(val, 0, "booting register");

    // received bytes with the full flag polled first
    for (i = 0; i < 3; i++) begin
      val = '0;
      while (val[0] !== 1'b1)
        read_reg(spif_io_pkg::IO_CODE_ADDR, val);
      read_reg(spif_io_pkg::IO_UART, val);
      check(val[7:0], RX_EXP[8*(2-i) +: 8], $sformatf("received byte %0d", i));
    end

    // transmit with escapes
    for (i = 0; i < 3; i++)
      write_reg(spif_io_pkg::IO_UART, TX_IN[8*(2-i) +: 8]);
    while (tx_seen.size() < 5)
      @(posedge clk);
    repeat (4) @(negedge clk);         // room for a stray byte
    check(tx_seen.size(), 5, "uart byte count");
    for (i = 0; i < 5; i++)
      check(tx_seen[i], TX_EXP[8*(4-i) +: 8], $sformatf("uart byte %0d", i));

    // processor code writes at consecutive addresses
    a16 = 16'h0100;
    for (i = 0; i < 3; i++) begin
      exp_wr.push_back({1'b0, a16, 2'b00, CODE_W[16*(2-i) +: 16]});
      a16 = a16 + 16'd1;
    end
    write_reg(spif_io_pkg::IO_CODE_ADDR, 18'h00100);
    for (i = 0; i < 3; i++)
      write_reg(spif_io_pkg::IO_CODE_DATA, {2'b00, CODE_W[16*(2-i) +: 16]});

    // processor data write, data read and code fetch
    exp_wr.push_back({1'b1, 16'h0033, 18'h2A5A5});
    @(negedge clk);
    mem_addr  = 15'h0033;
    din       = 18'h2A5A5;
    mem_wr    = 1'b1;
    code_addr = 15'h0155;
    @(posedge clk);
    check(code_rd, 1'b1, "code fetch enable");
    check(code_a, 10'h155, "code fetch address");
    @(negedge clk);
    mem_wr = 1'b0;
    mem_rd = 1'b1;
    @(posedge clk);
    check(data_rd, 1'b1, "data read enable");
    check(data_a, 10'h033, "data read address");
    @(negedge clk);
    mem_rd = 1'b0;
    check(exp_wr.size(), 0, "processor writes left over");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- tb_flash_model.sv
`timescale 1ns/10ps
//==============================
// SPI flash byte engine model
//==============================
module tb_flash_model #(
  parameter int                   IMG_LEN = 1,    // image bytes
  parameter logic [8*IMG_LEN-1:0] IMAGE   = '0,   // byte 0 in the top bits
  parameter int                   HDR_LEN = 5     // cmd, 3 addr, dummy
) (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_f_wr,      // transfer start
  output logic       o_f_ready,
  output logic [7:0] o_f_din
);

  int xfer;   // transfers started so far
  int lat;    // cycles left in this transfer

  // byte shifted out by the flash during transfer n, counted from 1
  function automatic logic [7:0] resp_byte(input int n);
    int k;
    k = n - HDR_LEN - 1;
    if (k < 0 || k >= IMG_LEN)
      return 8'hFF;                       // header slots, past the end
    return IMAGE[8*(IMG_LEN-1-k) +: 8];
  endfunction

  always @(negedge clk or negedge arstn) begin
    if (!arstn) begin
      o_f_ready <= 1'b1;
      o_f_din   <= 8'hFF;
      xfer      <= 0;
      lat       <= 0;
    end else if (i_f_wr) begin
      o_f_ready <= 1'b0;                  // busy shifting
      lat       <= $urandom % 6;          // random engine latency
      xfer      <= xfer + 1;
    end else if (!o_f_ready) begin
      if (lat == 0) begin
        o_f_ready <= 1'b1;
        o_f_din   <= resp_byte(xfer);     // byte of the finished transfer
      end else begin
        lat <= lat - 1;
      end
    end
  end

endmodule

//--- spif_top.sv
`timescale 1ns/10ps
//==============================
// serial flash boot controller
//==============================
module spif_top #(
  parameter int CODE_SIZE = 10,   // log2 code RAM depth
  parameter int WIDTH     = 18,   // data word size
  parameter int DATA_SIZE = 10,   // log2 data RAM depth
  parameter int BASEBLOCK = 0     // boot sector
) (
  input  logic                 clk,
  input  logic                 arstn,
  input  logic                 i_io_rd,
  input  logic                 i_io_wr,
  input  logic                 i_mem_rd,
  input  logic                 i_mem_wr,
  input  spif_io_pkg::addr_t   i_mem_addr,
  input  logic [WIDTH-1:0]     i_din,
  input  spif_io_pkg::addr_t   i_code_addr,
  output logic [WIDTH-1:0]     o_io_dout,
  output logic                 o_p_hold,
  output logic                 o_p_reset,
  output logic [DATA_SIZE-1:0] o_data_a,
  output logic [WIDTH-1:0]     o_data_din,
  output logic                 o_data_wr,
  output logic                 o_data_rd,
  output logic [CODE_SIZE-1:0] o_code_a,
  output logic [15:0]          o_code_din,
  output logic                 o_code_wr,
  output logic                 o_code_rd,
  input  logic                 i_u_ready,
  output logic                 o_u_wr,
  output spif_io_pkg::byte_t   o_u_dout,
  input  logic                 i_u_full,
  output logic                 o_u_rd,
  input  spif_io_pkg::byte_t   i_u_din,
  input  logic                 i_f_ready,
  output logic                 o_f_wr,
  output spif_io_pkg::byte_t   o_f_dout,
  output spif_boot_pkg::fmt_t  o_f_format,
  input  spif_io_pkg::byte_t   i_f_din
);

  logic                 tx_wr;
  spif_io_pkg::byte_t   tx_byte;
  logic                 tx_busy;
  logic                 rx_clear;
  spif_io_pkg::byte_t   rx_byte;
  logic                 rx_full;
  logic                 boot_code_wr;
  logic                 boot_data_wr;
  spif_boot_pkg::dest_t boot_addr;
  logic [WIDTH-1:0]     boot_word;
  logic                 booting;

  uart_tx_escape u_tx (
    .clk(clk), .arstn(arstn),
    .i_tx_wr(tx_wr), .i_tx_byte(tx_byte), .o_tx_busy(tx_busy),
    .i_u_ready(i_u_ready), .o_u_wr(o_u_wr), .o_u_dout(o_u_dout)
  );

  uart_rx_unescape u_rx (
    .clk(clk), .arstn(arstn),
    .i_u_full(i_u_full), .i_u_din(i_u_din), .o_u_rd(o_u_rd),
    .i_rx_clear(rx_clear), .o_rx_byte(rx_byte), .o_rx_full(rx_full)
  );

  flash_boot #(.WIDTH(WIDTH), .BASEBLOCK(BASEBLOCK)) u_boot (
    .clk(clk), .arstn(arstn),
    .i_f_ready(i_f_ready), .i_f_din(i_f_din), .o_f_wr(o_f_wr),
    .o_f_dout(o_f_dout), .o_f_format(o_f_format),
    .o_boot_code_wr(boot_code_wr), .o_boot_data_wr(boot_data_wr),
    .o_boot_addr(boot_addr), .o_boot_word(boot_word),
    .o_booting(booting), .o_p_reset(o_p_reset)
  );

  cpu_io_regs #(.WIDTH(WIDTH), .CODE_SIZE(CODE_SIZE), .DATA_SIZE(DATA_SIZE)) u_io (
    .clk(clk), .arstn(arstn),
    .i_io_rd(i_io_rd), .i_io_wr(i_io_wr), .i_mem_rd(i_mem_rd), .i_mem_wr(i_mem_wr),
    .i_mem_addr(i_mem_addr), .i_din(i_din), .i_code_addr(i_code_addr),
    .o_io_dout(o_io_dout), .o_p_hold(o_p_hold),
    .i_boot_code_wr(boot_code_wr), .i_boot_data_wr(boot_data_wr),
    .i_boot_addr(boot_addr), .i_boot_word(boot_word), .i_booting(booting),
    .o_tx_wr(tx_wr), .o_tx_byte(tx_byte), .i_tx_busy(tx_busy),
    .o_rx_clear(rx_clear), .i_rx_byte(rx_byte), .i_rx_full(rx_full),
    .o_data_a(o_data_a), .o_data_din(o_data_din), .o_data_wr(o_data_wr),
    .o_data_rd(o_data_rd), .o_code_a(o_code_a), .o_code_din(o_code_din),
    .o_code_wr(o_code_wr), .o_code_rd(o_code_rd)
  );

endmodule

//--- cpu_io_regs.sv
`timescale 1ns/10ps
//==============================
// processor I/O and RAM ports
//==============================
module cpu_io_regs #(
  parameter int WIDTH     = 18,   // data word size
  parameter int CODE_SIZE = 10,   // log2 code RAM depth
  parameter int DATA_SIZE = 10    // log2 data RAM depth
) (
  input  logic                 clk,
  input  logic                 arstn,
  input  logic                 i_io_rd,
  input  logic                 i_io_wr,
  input  logic                 i_mem_rd,
  input  logic                 i_mem_wr,
  input  spif_io_pkg::addr_t   i_mem_addr,
  input  logic [WIDTH-1:0]     i_din,
  input  spif_io_pkg::addr_t   i_code_addr,
  output logic [WIDTH-1:0]     o_io_dout,
  output logic                 o_p_hold,
  input  logic                 i_boot_code_wr,
  input  logic                 i_boot_data_wr,
  input  spif_boot_pkg::dest_t i_boot_addr,
  input  logic [WIDTH-1:0]     i_boot_word,
  input  logic                 i_booting,
  output logic                 o_tx_wr,
  output spif_io_pkg::byte_t   o_tx_byte,
  input  logic                 i_tx_busy,
  output logic                 o_rx_clear,
  input  spif_io_pkg::byte_t   i_rx_byte,
  input  logic                 i_rx_full,
  output logic [DATA_SIZE-1:0] o_data_a,
  output logic [WIDTH-1:0]     o_data_din,
  output logic                 o_data_wr,
  output logic                 o_data_rd,
  output logic [CODE_SIZE-1:0] o_code_a,
  output logic [15:0]          o_code_din,
  output logic                 o_code_wr,
  output logic                 o_code_rd
);

  spif_io_pkg::io_sel_t io_sel;
  logic                 tx_sel;        // write to the UART register
  logic                 cpu_code_wr;   // processor code word write
  logic [CODE_SIZE-1:0] code_ptr;

  assign io_sel      = i_mem_addr[3:0];
  assign tx_sel      = i_io_wr & (io_sel == spif_io_pkg::IO_UART);
  assign o_p_hold    = i_boot_code_wr | i_boot_data_wr | (tx_sel & i_tx_busy);
  assign o_tx_wr     = tx_sel & ~o_p_hold;
  assign o_tx_byte   = i_din[7:0];
  assign o_rx_clear  = i_io_rd & (io_sel == spif_io_pkg::IO_UART) & ~o_p_hold;
  assign cpu_code_wr = i_io_wr & (io_sel == spif_io_pkg::IO_CODE_DATA) & ~o_p_hold;

  // processor code pointer
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      code_ptr <= '0;
    end else if (i_io_wr && !o_p_hold) begin
      if (io_sel == spif_io_pkg::IO_CODE_ADDR)
        code_ptr <= i_din[CODE_SIZE-1:0];
      else if (io_sel == spif_io_pkg::IO_CODE_DATA)
        code_ptr <= code_ptr + 1'b1;     // next word
    end
  end

  // read mux, flags zero extended
  always_comb begin
    o_io_dout = '0;
    case (io_sel)
      spif_io_pkg::IO_UART:      o_io_dout[7:0] = i_rx_byte;
      spif_io_pkg::IO_CODE_ADDR: o_io_dout[0]   = i_rx_full;
      spif_io_pkg::IO_CODE_DATA: o_io_dout[0]   = i_tx_busy;
      spif_io_pkg::IO_BOOTING:   o_io_dout[0]   = i_booting;
      default:                   o_io_dout      = '0;
    endcase
  end

  //==============================
  // RAM ports, boot writes first
  //==============================
  assign o_code_wr  = i_boot_code_wr | cpu_code_wr;
  assign o_code_a   = i_boot_code_wr ? i_boot_addr[CODE_SIZE-1:0] :
                      cpu_code_wr    ? code_ptr : i_code_addr[CODE_SIZE-1:0];
  assign o_code_din = i_boot_code_wr ? i_boot_word[15:0] : i_din[15:0];
  assign o_code_rd  = ~o_p_hold & ~cpu_code_wr;   // fetch address taken
  assign o_data_wr  = i_boot_data_wr | (i_mem_wr & ~o_p_hold);
  assign o_data_a   = i_boot_data_wr ? i_boot_addr[DATA_SIZE-1:0] :
                      i_mem_addr[DATA_SIZE-1:0];
  assign o_data_din = i_boot_data_wr ? i_boot_word : i_din;
  assign o_data_rd  = i_mem_rd & ~o_p_hold;

endmodule

//--- flash_boot.sv
`timescale 1ns/10ps
//==============================
// flash boot interpreter
//==============================
module flash_boot #(
  parameter int WIDTH     = 18,   // data word size
  parameter int BASEBLOCK = 0     // 64 KB sector holding the image
) (
  input  logic                  clk,
  input  logic                  arstn,
  input  logic                  i_f_ready,       // engine idle, din valid
  input  spif_io_pkg::byte_t    i_f_din,
  output logic                  o_f_wr,
  output spif_io_pkg::byte_t    o_f_dout,
  output spif_boot_pkg::fmt_t   o_f_format,
  output logic                  o_boot_code_wr,
  output logic                  o_boot_data_wr,
  output spif_boot_pkg::dest_t  o_boot_addr,
  output logic [WIDTH-1:0]      o_boot_word,
  output logic                  o_booting,
  output logic                  o_p_reset
);

  // what the next image byte means
  typedef enum logic [2:0] {
    M_CMD, M_DEST_HI, M_DEST_LO, M_CNT_HI, M_CNT_LO, M_DATA
  } mode_t;

  spif_boot_pkg::boot_state_t state;
  mode_t                      mode;
  spif_boot_pkg::count_t      count;      // words left minus one
  logic [1:0]                 bytes;      // bytes per word minus one
  logic [1:0]                 byte_cnt;
  logic [2:0]                 sink;
  logic                       dummy_sent;
  logic                       bump;       // word done, advance address
  logic                       f_ok;
  logic                       take;       // image byte on i_f_din

  assign f_ok      = i_f_ready & ~o_f_wr;
  assign take      = f_ok & (state == spif_boot_pkg::INTERP);
  assign o_booting = (state != spif_boot_pkg::IDLE);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state          <= spif_boot_pkg::CMD;
      mode           <= M_CMD;
      o_f_wr         <= 1'b0;
      o_f_format     <= spif_boot_pkg::FMT_OFF;
      o_p_reset      <= 1'b1;                  // cpu held during boot
      o_boot_code_wr <= 1'b0;
      o_boot_data_wr <= 1'b0;
      o_boot_addr    <= '0;
      count          <= '0;
      bytes          <= 2'd0;
      byte_cnt       <= 2'd0;
      sink           <= 3'd0;
      dummy_sent     <= 1'b0;
      bump           <= 1'b0;
    end else begin
      o_f_wr         <= 1'b0;                  // strobes
      o_boot_code_wr <= 1'b0;
      o_boot_data_wr <= 1'b0;
      bump           <= 1'b0;
      if (bump)
        o_boot_addr <= o_boot_addr + 1'b1;
      if (f_ok && o_booting) begin
        o_f_wr <= 1'b1;                        // next transfer
        case (state)
          spif_boot_pkg::CMD: begin
            o_f_format <= spif_boot_pkg::FMT_SINGLE;
            state      <= spif_boot_pkg::ADDR_HI;
          end
          spif_boot_pkg::ADDR_HI: state <= spif_boot_pkg::ADDR_LO;
          spif_boot_pkg::ADDR_LO: state <= spif_boot_pkg::ADDR_0;
          spif_boot_pkg::ADDR_0:  state <= spif_boot_pkg::DUMMY;
          spif_boot_pkg::DUMMY: begin          // dummy, then first request
            dummy_sent <= 1'b1;
            if (dummy_sent)
              state <= spif_boot_pkg::INTERP;
          end
          spif_boot_pkg::INTERP: begin
            case (mode)
              M_CMD: begin
                if (i_f_din[7:6] == spif_boot_pkg::CMD_CTRL) begin
                  if (i_f_din[5]) begin        // end of image
                    o_f_wr     <= 1'b0;
                    o_f_format <= spif_boot_pkg::FMT_OFF;
                    o_p_reset  <= i_f_din[4];
                    state      <= spif_boot_pkg::IDLE;
                  end else if (i_f_din[0]) begin
                    mode <= M_CNT_HI;
                  end else begin
                    mode <= M_DEST_HI;
                  end
                end else if (i_f_din[7:6] != spif_boot_pkg::CMD_RATE) begin
                  mode     <= M_DATA;          // rate bytes fall through
                  sink     <= i_f_din[4:2];
                  bytes    <= i_f_din[1:0];
                  byte_cnt <= i_f_din[1:0];
                end
              end
              M_DEST_HI: begin
                o_boot_addr[15:8] <= i_f_din;
                mode              <= M_DEST_LO;
              end
              M_DEST_LO: begin
                o_boot_addr[7:0] <= i_f_din;
                mode             <= M_CMD;
              end
              M_CNT_HI: begin
                count[15:8] <= i_f_din;
                mode        <= M_CNT_LO;
              end
              M_CNT_LO: begin
                count[7:0] <= i_f_din;
                mode       <= M_CMD;
              end
              M_DATA: begin
                if (byte_cnt != 2'd0) begin
                  byte_cnt <= byte_cnt - 2'd1;
                end else begin                 // last byte of word
                  byte_cnt       <= bytes;
                  bump           <= 1'b1;
                  o_boot_code_wr <= (sink == 3'd0);
                  o_boot_data_wr <= (sink == 3'd1);
                  if (count != '0)
                    count <= count - 1'b1;
                  else
                    mode <= M_CMD;
                end
              end
              default: mode <= M_CMD;
            endcase
          end
          default: state <= spif_boot_pkg::IDLE;
        endcase
      end
    end
  end

  // outgoing flash byte and word assembly, msb first
  always_ff @(posedge clk) begin
    if (f_ok) begin
      case (state)
        spif_boot_pkg::CMD:     o_f_dout <= spif_boot_pkg::FAST_READ;
        spif_boot_pkg::ADDR_HI: o_f_dout <= 8'(BASEBLOCK);
        default:                o_f_dout <= 8'h00;
      endcase
    end
    if (bump || (take && mode != M_DATA))
      o_boot_word <= '0;
    else if (take)
      o_boot_word <= {o_boot_word[WIDTH-9:0], i_f_din};
  end

endmodule

//--- uart_rx_unescape.sv
`timescale 1ns/10ps
//==============================
// UART receive unescaping
//==============================
module uart_rx_unescape (
  input  logic               clk,
  input  logic               arstn,
  input  logic               i_u_full,    // UART holds a raw byte
  input  spif_io_pkg::byte_t i_u_din,
  output logic               o_u_rd,
  input  logic               i_rx_clear,  // processor read the byte
  output spif_io_pkg::byte_t o_rx_byte,
  output logic               o_rx_full
);

  typedef enum logic {
    IDLE,   // plain byte or prefix
    ESC     // second byte of a pair
  } rx_state_t;

  rx_state_t state;
  logic      u_ok;     // raw byte can be looked at
  logic      is_pre;   // escape prefix
  logic      is_low;   // 00h..03h

  assign u_ok   = i_u_full & ~o_u_rd;
  assign is_pre = (i_u_din == spif_io_pkg::ESC_BYTE);
  assign is_low = (i_u_din[7:2] == 6'd0);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= IDLE;
      o_u_rd    <= 1'b0;
      o_rx_full <= 1'b0;
    end else begin
      o_u_rd <= 1'b0;
      if (i_rx_clear)
        o_rx_full <= 1'b0;
      if (u_ok) begin
        case (state)
          IDLE: begin
            if (is_pre) begin             // prefix never waits
              o_u_rd <= 1'b1;
              state  <= ESC;
            end else if (!o_rx_full) begin
              o_u_rd    <= 1'b1;
              o_rx_full <= 1'b1;
            end
          end
          ESC: begin
            if (!is_low) begin            // bad pair, drop it
              o_u_rd <= 1'b1;
              state  <= IDLE;
            end else if (!o_rx_full) begin
              o_u_rd    <= 1'b1;
              o_rx_full <= 1'b1;
              state     <= IDLE;
            end
          end
        endcase
      end
    end
  end

  // holding register
  always_ff @(posedge clk) begin
    if (u_ok && !o_rx_full) begin
      if (state == IDLE && !is_pre)
        o_rx_byte <= i_u_din;
      else if (state == ESC && is_low)
        o_rx_byte <= {spif_io_pkg::ESC_MASK, i_u_din[1:0]};  // 10h + x
    end
  end

endmodule

//--- uart_tx_escape.sv
`timescale 1ns/10ps
//==============================
// UART transmit escaping
//==============================
module uart_tx_escape (
  input  logic               clk,
  input  logic               arstn,
  input  logic               i_tx_wr,     // byte from processor
  input  spif_io_pkg::byte_t i_tx_byte,
  output logic               o_tx_busy,
  input  logic               i_u_ready,   // UART can take a byte
  output logic               o_u_wr,
  output spif_io_pkg::byte_t o_u_dout
);

  logic       esc_pend;   // low code still to send
  logic [1:0] esc_low;    // low bits of escaped byte
  logic       is_esc;

  assign is_esc    = (i_tx_byte[7:2] == spif_io_pkg::ESC_MASK);
  assign o_tx_busy = ~i_u_ready | esc_pend | o_u_wr;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr   <= 1'b0;
      esc_pend <= 1'b0;
    end else begin
      o_u_wr <= 1'b0;                       // strobe
      if (esc_pend) begin
        if (i_u_ready && !o_u_wr) begin     // gap after the 10h
          o_u_wr   <= 1'b1;
          esc_pend <= 1'b0;
        end
      end else if (i_tx_wr) begin
        o_u_wr   <= 1'b1;
        esc_pend <= is_esc;
      end
    end
  end

  // outgoing byte and pending code
  always_ff @(posedge clk) begin
    if (esc_pend) begin
      if (i_u_ready && !o_u_wr)
        o_u_dout <= {6'd0, esc_low};        // 0xh second byte
    end else if (i_tx_wr) begin
      esc_low  <= i_tx_byte[1:0];
      o_u_dout <= is_esc ? spif_io_pkg::ESC_BYTE : i_tx_byte;
    end
  end

endmodule

//--- spif_boot_pkg.sv
//==============================
// boot stream and flash format
//==============================
package spif_boot_pkg;

  // header states, then stream interpretation
  typedef enum logic [2:0] {
    IDLE,     // boot finished
    CMD,      // read command
    ADDR_HI,  // sector byte
    ADDR_LO,
    ADDR_0,
    DUMMY,    // dummy byte + first data request
    INTERP    // interpret image bytes
  } boot_state_t;

  localparam logic [7:0] FAST_READ = 8'h0B;  // flash fast read

  typedef logic [2:0] fmt_t;                  // flash frame format
  localparam fmt_t FMT_OFF    = 3'd0;         // CS# high
  localparam fmt_t FMT_SINGLE = 3'd2;         // single rate SPI

  typedef logic [15:0] dest_t;                // RAM destination address
  typedef logic [15:0] count_t;               // words per run minus one

  // command byte, bits 7:6
  localparam logic [1:0] CMD_CTRL = 2'b11;    // end or two-byte load
  localparam logic [1:0] CMD_RATE = 2'b10;    // sclk rate, not used here

endpackage

//--- spif_io_pkg.sv
//==============================
// processor I/O map and UART escape
//==============================
package spif_io_pkg;

  typedef logic [7:0]  byte_t;    // UART and flash bytes
  typedef logic [3:0]  io_sel_t;  // I/O register select, low address bits
  typedef logic [14:0] addr_t;    // processor data/code address

  //==============================
  // I/O registers
  //==============================
  localparam io_sel_t IO_UART      = 4'h0;  // wr: tx byte, rd: rx byte + clear
  localparam io_sel_t IO_CODE_ADDR = 4'h1;  // wr: code pointer, rd: rx full
  localparam io_sel_t IO_CODE_DATA = 4'h2;  // wr: code word, rd: tx busy
  localparam io_sel_t IO_BOOTING   = 4'h5;  // rd: boot still running

  //==============================
  // UART escape
  //==============================
  localparam byte_t      ESC_BYTE = 8'h10;       // escape prefix
  localparam logic [5:0] ESC_MASK = 6'b000100;   // upper bits of 10h..13h

endpackage
